// ==== compile.f ====
rtl/i2c_bus_pkg.sv
rtl/i2c_cmd_pkg.sv
rtl/i2c_line_filter.sv
rtl/i2c_clock_gen.sv
rtl/i2c_bus_monitor.sv
rtl/i2c_bit_fsm.sv
rtl/i2c_bit_ctrl.sv
testbench/i2c_bit_ctrl_properties.sv
testbench/tb_i2c_bit_ctrl.sv

// ==== testbench/tb_i2c_bit_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the i2c bit controller
// clock and reset, open-drain bus model with slave and second master,
// stimulus table with expected results, compare tasks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_i2c_bit_ctrl
    import i2c_bus_pkg::*;
    import i2c_cmd_pkg::*;
();

    // one table row per bit command
    typedef struct packed
    {
        i2c_cmd_req_t req;
        logic         slave_sda;  // slave's bit for reads
        logic         master_sda; // other master, 0 = pulls low
        logic [7:0]   stretch;    // slave holds scl low this many cycles
        logic         exp_dout;
        bus_status_t  exp_status;
    } step_t;

    localparam prescale_t   PRESCALE   = 16'd3;
    localparam int          WAIT_LIMIT = 600;   // cycles per wait loop
    localparam int          AL_QUIET   = 16;    // cycles watched for a stray ack
    localparam int unsigned SEED       = 24551;

    logic         clk;
    logic         nReset;
    logic         ena;
    prescale_t    prescale;
    i2c_cmd_req_t req;
    logic         cmd_ack;
    logic         dout;
    bus_status_t  status;
    i2c_lines_t   oen;
    i2c_lines_t   slave_pull;  // 0 pulls the line low
    i2c_lines_t   master_pull; // second master on the bus
    i2c_lines_t   bus;         // wired-and of all drivers
    int unsigned  rand_state;
    step_t        steps[$];

    assign bus = i2c_lines_t'(oen & slave_pull & master_pull);

    i2c_bit_ctrl dut (
        .clk      (clk),
        .nReset   (nReset),
        .ena      (ena),
        .prescale (prescale),
        .req      (req),
        .lines_in (bus),
        .cmd_ack  (cmd_ack),
        .dout     (dout),
        .status   (status),
        .oen      (oen)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk; // 20 ns period

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic int unsigned lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 16; // upper bits, better spread
    endfunction

    // long enough to outlast the phases before scl is released
    function automatic logic [7:0] random_stretch();
        return 8'(12 + lcg_next() % 32);
    endfunction

    function automatic step_t make_step(input i2c_cmd_e cmd, input logic din,
                                        input logic slave_sda, input logic master_sda,
                                        input logic [7:0] stretch, input logic exp_dout,
                                        input logic exp_busy, input logic exp_al);
        step_t s;
        s.req        = '{cmd: cmd, din: din};
        s.slave_sda  = slave_sda;
        s.master_sda = master_sda;
        s.stretch    = stretch;
        s.exp_dout   = exp_dout;
        s.exp_status = '{busy: exp_busy, al: exp_al};
        return s;
    endfunction

    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout: %s did not happen within %0d clock cycles", what, WAIT_LIMIT);
        stop_on_failure();
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0d ns: %s, got %b expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_lines(input i2c_lines_t got, input i2c_lines_t exp,
                               input string what);
        if (got !== exp)
        begin
            $display("ERR %0d ns: %s, got scl=%b sda=%b expected scl=%b sda=%b",
                     $time, what, got.scl, got.sda, exp.scl, exp.sda);
            stop_on_failure();
        end
    endtask

    task automatic check_status(input bus_status_t got, input bus_status_t exp,
                                input string what);
        if (got !== exp)
        begin
            $display("ERR %0d ns: %s, got busy=%b al=%b expected busy=%b al=%b",
                     $time, what, got.busy, got.al, exp.busy, exp.al);
            stop_on_failure();
        end
    endtask

    // bound property checker on the dut
    always @(dut.u_properties.fail_count)
        if (dut.u_properties.fail_count != 0)
        begin
            $display("a bound assertion on the DUT failed");
            stop_on_failure();
        end

    // present one command, run the bus model until cmd_ack or al
    task automatic run_command(input step_t s, output logic got_al);
        int   cycles;
        logic done;
        @(posedge clk);
        #1;
        req             = s.req;
        slave_pull.sda  = s.slave_sda;
        master_pull.sda = s.master_sda;
        if (s.stretch != 0)
            slave_pull.scl = 1'b0; // slave starts stretching, scl already low
        cycles = 0;
        done   = 1'b0;
        got_al = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (status.al)
            begin
                got_al = 1'b1;
                done   = 1'b1;
            end
            else if (cmd_ack)
            begin
                check_bit(slave_pull.scl, 1'b1, "cmd_ack while slave holds scl low");
                done = 1'b1;
            end
            else
            begin
                if (s.req.cmd == CMD_WRITE && oen.scl)
                    check_bit(oen.sda, s.req.din, "sda enable vs din under released scl");
                if (!slave_pull.scl && cycles >= s.stretch)
                    slave_pull.scl = 1'b1; // end of stretch
                if (cycles >= WAIT_LIMIT)
                    fail_timeout("cmd_ack or arbitration lost");
            end
        end
    endtask

    task automatic drop_request();
        @(posedge clk);
        #1;
        req = '{cmd: CMD_NOP, din: 1'b0};
    endtask

    task automatic wait_busy(input logic level);
        int cycles;
        cycles = 0;
        while (status.busy !== level)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= WAIT_LIMIT)
                fail_timeout("busy change");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table: cmd din slave master stretch dout busy al
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        steps.push_back(make_step(CMD_START, 0, 1, 1, 0, 0, 1, 0));
        steps.push_back(make_step(CMD_WRITE, 1, 1, 1, 0, 0, 1, 0));
        steps.push_back(make_step(CMD_WRITE, 0, 1, 1, 0, 0, 1, 0));
        steps.push_back(make_step(CMD_READ,  0, 1, 1, 0, 1, 1, 0));
        steps.push_back(make_step(CMD_READ,  0, 0, 1, 0, 0, 1, 0));
        steps.push_back(make_step(CMD_WRITE, 1, 1, 1, random_stretch(), 0, 1, 0));
        steps.push_back(make_step(CMD_READ,  0, 0, 1, random_stretch(), 0, 1, 0));
        steps.push_back(make_step(CMD_READ,  0, 1, 1, random_stretch(), 1, 1, 0));
        steps.push_back(make_step(CMD_START, 0, 1, 1, 0, 0, 1, 0)); // repeated start
        steps.push_back(make_step(CMD_WRITE, 0, 1, 1, random_stretch(), 0, 1, 0));
        steps.push_back(make_step(CMD_STOP,  0, 1, 1, 0, 0, 0, 0));
        steps.push_back(make_step(CMD_START, 0, 1, 1, 0, 0, 1, 0));
        steps.push_back(make_step(CMD_WRITE, 1, 1, 0, 0, 0, 1, 1)); // other master wins
        steps.push_back(make_step(CMD_START, 0, 1, 1, 0, 0, 1, 0));
        steps.push_back(make_step(CMD_READ,  0, 1, 1, 0, 1, 1, 0));
        steps.push_back(make_step(CMD_STOP,  0, 1, 1, 0, 0, 0, 0));
    endtask

    initial
    begin
        logic got_al;
        nReset      = 1'b0;
        ena         = 1'b1;
        prescale    = PRESCALE;
        req         = '{cmd: CMD_NOP, din: 1'b0};
        slave_pull  = LINES_IDLE;
        master_pull = LINES_IDLE;
        rand_state  = SEED;
        build_table();

        repeat (4) @(posedge clk);
        #1;
        nReset = 1'b1;
        @(posedge clk);
        #1;
        check_lines(oen, LINES_IDLE, "enables after reset");
        check_status(status, '{busy: 1'b0, al: 1'b0}, "status after reset");
        check_bit(cmd_ack, 1'b0, "cmd_ack after reset");

        foreach (steps[i])
        begin
            run_command(steps[i], got_al);
            check_bit(got_al, steps[i].exp_status.al, "arbitration lost flag");
            if (got_al)
            begin
                check_status(status, steps[i].exp_status, "status on arbitration lost");
                drop_request();
                check_lines(oen, LINES_IDLE, "enables after arbitration lost");
                repeat (AL_QUIET)
                begin
                    @(posedge clk);
                    #1;
                    check_bit(cmd_ack, 1'b0, "cmd_ack after arbitration lost");
                end
                master_pull.sda = 1'b1; // winner lets go, looks like a stop
                wait_busy(1'b0);
                check_status(status, '{busy: 1'b0, al: 1'b0}, "status after bus freed");
            end
            else
            begin
                if (steps[i].req.cmd == CMD_READ)
                    check_bit(dout, steps[i].exp_dout, "read data at cmd_ack");
                if (steps[i].req.cmd == CMD_WRITE || steps[i].req.cmd == CMD_READ)
                    check_status(status, steps[i].exp_status, "status at cmd_ack");
                drop_request();
                if (steps[i].req.cmd == CMD_START)
                begin
                    wait_busy(1'b1); // start seen through the filter
                    check_status(status, steps[i].exp_status, "status after start");
                end
                if (steps[i].req.cmd == CMD_STOP)
                begin
                    wait_busy(1'b0);
                    check_status(status, steps[i].exp_status, "status after stop");
                    check_lines(bus, LINES_IDLE, "bus lines after stop");
                    check_lines(oen, LINES_IDLE, "enables after stop");
                end
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== testbench/i2c_bit_ctrl_properties.sv ====
////////////////////////////////////////////////////////////////////////////
// concurrent assertions on the i2c bit controller top level
// single-cycle ack, release after al, sda stable under released scl
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module i2c_bit_ctrl_properties
    import i2c_bus_pkg::*;
    import i2c_cmd_pkg::*;
(
    input logic         clk,
    input logic         nReset,
    input logic         cmd_ack,
    input i2c_cmd_req_t req,
    input bus_status_t  status,
    input i2c_lines_t   oen
);

    logic        start_stop;     // sda may move under high scl only here
    int unsigned fail_count = 0; // failed assertions so far

    assign start_stop = (req.cmd == CMD_START) || (req.cmd == CMD_STOP);

    ack_one_cycle: assert property (@(posedge clk) disable iff (!nReset)
        cmd_ack |=> !cmd_ack)
        else
        begin
            $error("cmd_ack high for two cycles");
            fail_count++;
        end

    al_releases_bus: assert property (@(posedge clk) disable iff (!nReset)
        status.al |=> (oen == LINES_IDLE))
        else
        begin
            $error("line enables not released after arbitration lost");
            fail_count++;
        end

    // data only changes while scl is held low
    sda_stable_scl_high: assert property (@(posedge clk) disable iff (!nReset)
        (oen.scl && $past(oen.scl) && !start_stop && !status.al && !$past(status.al))
        |-> $stable(oen.sda))
        else
        begin
            $error("sda enable changed while scl enable released");
            fail_count++;
        end

endmodule

bind i2c_bit_ctrl i2c_bit_ctrl_properties u_properties (
    .clk     (clk),
    .nReset  (nReset),
    .cmd_ack (cmd_ack),
    .req     (req),
    .status  (status),
    .oen     (oen)
);

// ==== rtl/i2c_bit_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// i2c bit controller top level
// line filter, clock generator, bus monitor and bit fsm
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module i2c_bit_ctrl
    import i2c_bus_pkg::*;
    import i2c_cmd_pkg::*;
(
    input  logic         clk,
    input  logic         nReset,
    input  logic         ena,      // core enable
    input  prescale_t    prescale,
    input  i2c_cmd_req_t req,      // held until cmd_ack
    input  i2c_lines_t   lines_in, // pad inputs
    output logic         cmd_ack,
    output logic         dout,
    output bus_status_t  status,
    output i2c_lines_t   oen       // pad enables, 0 pulls low
);

    i2c_lines_t lines_f;    // filtered
    i2c_lines_t lines_d;    // filtered, delayed
    logic       clk_en;     // phase strobe
    logic       sda_chk;
    logic       fsm_active;

    i2c_line_filter u_filter (
        .clk      (clk),
        .nReset   (nReset),
        .ena      (ena),
        .prescale (prescale),
        .lines_in (lines_in),
        .lines_f  (lines_f),
        .lines_d  (lines_d)
    );

    i2c_clock_gen u_clk_gen (
        .clk      (clk),
        .nReset   (nReset),
        .ena      (ena),
        .prescale (prescale),
        .scl_oen  (oen.scl),
        .lines_f  (lines_f),
        .lines_d  (lines_d),
        .clk_en   (clk_en)
    );

    i2c_bus_monitor u_monitor (
        .clk        (clk),
        .nReset     (nReset),
        .clk_en     (clk_en),
        .sda_chk    (sda_chk),
        .fsm_active (fsm_active),
        .req        (req),
        .oen        (oen),
        .lines_f    (lines_f),
        .lines_d    (lines_d),
        .status     (status),
        .dout       (dout)
    );

    // al loops back as the fsm abort
    i2c_bit_fsm u_fsm (
        .clk        (clk),
        .nReset     (nReset),
        .clk_en     (clk_en),
        .al         (status.al),
        .req        (req),
        .cmd_ack    (cmd_ack),
        .oen        (oen),
        .sda_chk    (sda_chk),
        .fsm_active (fsm_active)
    );

endmodule

// ==== rtl/i2c_bit_fsm.sv ====
////////////////////////////////////////////////////////////////////////////
// bit command sequencer
// one-hot fsm, one state per phase strobe, drives scl/sda enables
//
// start  scl ~~~~~~~~~~\__   sda ~~~~~~\______
// stop   scl __/~~~~~~~~~~   sda ==\____/~~~~~
// write  scl __/~~~~\_____   sda ==X=========X
// read   scl __/~~~~\_____   sda xxx=====xxxxx
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module i2c_bit_fsm
    import i2c_bus_pkg::*;
    import i2c_cmd_pkg::*;
(
    input  logic         clk,
    input  logic         nReset,
    input  logic         clk_en,     // phase strobe
    input  logic         al,         // arbitration lost, abort
    input  i2c_cmd_req_t req,
    output logic         cmd_ack,    // one-cycle done pulse
    output i2c_lines_t   oen,        // 1 = released
    output logic         sda_chk,    // compare sda in this phase
    output logic         fsm_active
);

    // idle is all zero, one bit per command phase
    typedef enum logic [17:0]
    {
        IDLE    = 18'h0,
        START_A = 18'h00001,
        START_B = 18'h00002,
        START_C = 18'h00004,
        START_D = 18'h00008,
        START_E = 18'h00010,
        STOP_A  = 18'h00020,
        STOP_B  = 18'h00040,
        STOP_C  = 18'h00080,
        STOP_D  = 18'h00100,
        RD_A    = 18'h00200,
        RD_B    = 18'h00400,
        RD_C    = 18'h00800,
        RD_D    = 18'h01000,
        WR_A    = 18'h02000,
        WR_B    = 18'h04000,
        WR_C    = 18'h08000,
        WR_D    = 18'h10000
    } state_e;

    state_e state;

    assign fsm_active = |state;

    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
        begin
            state   <= IDLE;
            cmd_ack <= 1'b0;
            oen     <= LINES_IDLE;
            sda_chk <= 1'b0;
        end
        else if (al)
        begin
            state   <= IDLE; // drop everything, release the bus
            cmd_ack <= 1'b0;
            oen     <= LINES_IDLE;
            sda_chk <= 1'b0;
        end
        else
        begin
            cmd_ack <= 1'b0; // single-cycle ack
            if (clk_en)
            begin
                sda_chk <= 1'b0; // only set in wr_c
                unique case (state)
                    IDLE:
                        case (req.cmd)
                            CMD_START: state <= START_A;
                            CMD_STOP:  state <= STOP_A;
                            CMD_WRITE: state <= WR_A;
                            CMD_READ:  state <= RD_A;
                            default:   state <= IDLE;  // lines keep their level
                        endcase

                    ////////////////////////////////////////////////////////////////////////////
                    // start / repeated start
                    ////////////////////////////////////////////////////////////////////////////
                    START_A:
                    begin
                        state   <= START_B;
                        oen.sda <= 1'b1; // sda up, scl as it was
                    end
                    START_B:
                    begin
                        state   <= START_C;
                        oen.scl <= 1'b1; // scl up
                    end
                    START_C:
                    begin
                        state   <= START_D;
                        oen.sda <= 1'b0; // sda falls under high scl
                    end
                    START_D: state <= START_E; // hold time
                    START_E:
                    begin
                        state   <= IDLE;
                        cmd_ack <= 1'b1;
                        oen.scl <= 1'b0; // scl low
                    end

                    // stop
                    STOP_A:
                    begin
                        state <= STOP_B;
                        oen   <= '{scl: 1'b0, sda: 1'b0};
                    end
                    STOP_B:
                    begin
                        state   <= STOP_C;
                        oen.scl <= 1'b1; // scl up, sda still low
                    end
                    STOP_C: state <= STOP_D; // setup time
                    STOP_D:
                    begin
                        state   <= IDLE;
                        cmd_ack <= 1'b1;
                        oen.sda <= 1'b1; // sda rises under high scl
                    end

                    // read, sda released throughout
                    RD_A:
                    begin
                        state <= RD_B;
                        oen   <= '{scl: 1'b0, sda: 1'b1};
                    end
                    RD_B:
                    begin
                        state   <= RD_C;
                        oen.scl <= 1'b1;
                    end
                    RD_C: state <= RD_D;
                    RD_D:
                    begin
                        state   <= IDLE;
                        cmd_ack <= 1'b1;
                        oen.scl <= 1'b0;
                    end

                    ////////////////////////////////////////////////////////////////////////////
                    // write, din held by host until ack
                    ////////////////////////////////////////////////////////////////////////////
                    WR_A:
                    begin
                        state <= WR_B;
                        oen   <= '{scl: 1'b0, sda: req.din};
                    end
                    WR_B:
                    begin
                        state   <= WR_C;
                        oen.scl <= 1'b1; // let lines settle before checking
                    end
                    WR_C:
                    begin
                        state   <= WR_D;
                        sda_chk <= 1'b1; // arbitration window
                    end
                    WR_D:
                    begin
                        state   <= IDLE;
                        cmd_ack <= 1'b1;
                        oen.scl <= 1'b0;
                    end

                    default: state <= IDLE;
                endcase
            end
        end

endmodule

// ==== rtl/i2c_bus_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// bus observer
// start/stop detection, busy flag, arbitration lost, read sampling
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module i2c_bus_monitor
    import i2c_bus_pkg::*;
    import i2c_cmd_pkg::*;
(
    input  logic         clk,
    input  logic         nReset,
    input  logic         clk_en,     // phase strobe
    input  logic         sda_chk,    // fsm wants sda compared
    input  logic         fsm_active, // fsm not idle
    input  i2c_cmd_req_t req,
    input  i2c_lines_t   oen,        // our line enables
    input  i2c_lines_t   lines_f,
    input  i2c_lines_t   lines_d,
    output bus_status_t  status,
    output logic         dout        // sampled read bit
);

    logic sta_cond; // sda fell with scl high
    logic sto_cond; // sda rose with scl high
    logic busy;
    logic cmd_stop; // current command is a stop
    logic al;

    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
        begin
            sta_cond <= 1'b0;
            sto_cond <= 1'b0;
        end
        else
        begin
            sta_cond <= ~lines_f.sda &  lines_d.sda & lines_f.scl;
            sto_cond <=  lines_f.sda & ~lines_d.sda & lines_f.scl;
        end

    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
            busy <= 1'b0;
        else
            busy <= (sta_cond | busy) & ~sto_cond;

    // latched per phase, stop by another master is only legal if we asked for it
    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
            cmd_stop <= 1'b0;
        else if (clk_en)
            cmd_stop <= (req.cmd == CMD_STOP);

    // lost when we release sda but it reads low, or an unrequested stop shows up
    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
            al <= 1'b0;
        else
            al <= (sda_chk & ~lines_f.sda & oen.sda) |
                  (fsm_active & sto_cond & ~cmd_stop);

    // read data taken on rising scl
    always_ff @(posedge clk)
        if (lines_f.scl & ~lines_d.scl)
            dout <= lines_f.sda;

    assign status = '{busy: busy, al: al};

endmodule

// ==== rtl/i2c_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// phase enable generator
// prescale down-counter, slave clock stretching, multi-master scl sync
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module i2c_clock_gen import i2c_bus_pkg::*;
(
    input  logic       clk,
    input  logic       nReset,
    input  logic       ena,
    input  prescale_t  prescale,
    input  logic       scl_oen, // our scl enable, 1 = released
    input  i2c_lines_t lines_f,
    input  i2c_lines_t lines_d,
    output logic       clk_en   // one pulse per phase
);

    logic      dscl_oen;   // scl_oen one clk later
    logic      slave_wait; // slave holding scl low
    logic      scl_sync;   // other master pulled scl low
    prescale_t cnt;        // phase down-counter

    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
            dscl_oen <= 1'b1;
        else
            dscl_oen <= scl_oen;

    // set when we just released scl but it stays low
    // held until the line actually rises
    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
            slave_wait <= 1'b0;
        else
            slave_wait <= (scl_oen & ~dscl_oen & ~lines_f.scl) |
                          (slave_wait & ~lines_f.scl);

    // scl falls while we release it, restart our low period now
    assign scl_sync = lines_d.scl & ~lines_f.scl & scl_oen;

    ////////////////////////////////////////////////////////////////////////////
    // prescaler
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
        begin
            cnt    <= '0;
            clk_en <= 1'b1;
        end
        else if (cnt == '0 || !ena || scl_sync)
        begin
            cnt    <= prescale; // reload, start next phase
            clk_en <= 1'b1;
        end
        else
        begin
            if (!slave_wait)
                cnt <= cnt - 1'b1; // frozen while stretched
            clk_en <= 1'b0;
        end

endmodule

// ==== rtl/i2c_line_filter.sv ====
////////////////////////////////////////////////////////////////////////////
// scl/sda input conditioning
// two-flop capture, filter prescaler, 3-tap majority vote
// and one-cycle delayed copies of the filtered lines
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module i2c_line_filter import i2c_bus_pkg::*;
(
    input  logic       clk,
    input  logic       nReset,
    input  logic       ena,      // core enable
    input  prescale_t  prescale, // phase prescale value
    input  i2c_lines_t lines_in, // raw pad inputs
    output i2c_lines_t lines_f,  // filtered lines
    output i2c_lines_t lines_d   // filtered lines, one clk later
);

    i2c_lines_t              cap_q;      // first capture flop
    i2c_lines_t              cap_qq;     // second capture flop
    logic [FILTER_CNT_W-1:0] filter_cnt; // filter sample prescaler
    logic [2:0]              f_scl;      // scl taps
    logic [2:0]              f_sda;      // sda taps

    // 2 of 3 vote
    function automatic logic maj3(input logic [2:0] v);
        return (v[2] & v[1]) | (v[1] & v[0]) | (v[2] & v[0]);
    endfunction

    // capture pads, cuts metastability
    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
        begin
            cap_q  <= LINES_IDLE;
            cap_qq <= LINES_IDLE;
        end
        else
        begin
            cap_q  <= lines_in;
            cap_qq <= cap_q;
        end

    // sample tick at ~16x scl rate
    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
            filter_cnt <= '0;
        else if (!ena)
            filter_cnt <= '0;                               // parked while disabled
        else if (filter_cnt == '0)
            filter_cnt <= FILTER_CNT_W'(prescale >> FILTER_SHIFT);
        else
            filter_cnt <= filter_cnt - 1'b1;

    // shift captured lines into the taps on each tick
    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
        begin
            f_scl <= '1;
            f_sda <= '1;
        end
        else if (filter_cnt == '0)
        begin
            f_scl <= {f_scl[1:0], cap_qq.scl};
            f_sda <= {f_sda[1:0], cap_qq.sda};
        end

    // majority output plus delayed copy for edge detection
    always_ff @(posedge clk or negedge nReset)
        if (!nReset)
        begin
            lines_f <= LINES_IDLE;
            lines_d <= LINES_IDLE;
        end
        else
        begin
            lines_f <= '{scl: maj3(f_scl), sda: maj3(f_sda)};
            lines_d <= lines_f;
        end

endmodule

// ==== rtl/i2c_cmd_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// command side of the i2c bit controller
// command codes, request struct, bus status struct
////////////////////////////////////////////////////////////////////////////

package i2c_cmd_pkg;

    // bit-level commands, one hot apart from nop
    typedef enum logic [3:0]
    {
        CMD_NOP   = 4'd0,
        CMD_START = 4'd1, // start or repeated start
        CMD_STOP  = 4'd2,
        CMD_WRITE = 4'd4,
        CMD_READ  = 4'd8
    } i2c_cmd_e;

    // host request, held until cmd_ack
    typedef struct packed
    {
        i2c_cmd_e cmd;
        logic     din; // write data bit
    } i2c_cmd_req_t;

    // bus status seen by the host
    typedef struct packed
    {
        logic busy; // between start and stop
        logic al;   // arbitration lost pulse
    } bus_status_t;

endpackage

// ==== rtl/i2c_bus_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// line-level types for the i2c bit controller
// scl/sda pair struct, prescale type, filter constants
////////////////////////////////////////////////////////////////////////////

package i2c_bus_pkg;

    // one bit per bus line
    // as a sample: 1 = line high
    // as an enable: 1 = released (open drain)
    typedef struct packed
    {
        logic scl;
        logic sda;
    } i2c_lines_t;

    // system clocks per phase = value + 1
    typedef logic [15:0] prescale_t;

    ////////////////////////////////////////////////////////////////////////////
    // glitch filter
    ////////////////////////////////////////////////////////////////////////////

    localparam int FILTER_CNT_W = 14; // filter prescaler width
    localparam int FILTER_SHIFT = 2;  // prescale/4, ~16 samples per scl period

    // idle bus, both lines high / released
    localparam i2c_lines_t LINES_IDLE = '{scl: 1'b1, sda: 1'b1};

endpackage
